// File: neptuno_pkg.sv
// NeptUNO board shell definitions
// Bank count, ROM word and joystick widths, and the ROM word union
// shared by the download path and the memory controller

package neptuno_pkg;

    localparam int NBANKS   = 2;        // Game read banks
    localparam int DATAW    = 16;       // ROM word width
    localparam int JOYW     = 8;        // One decoded joystick
    localparam int JOY_BITS = 2 * JOYW; // Serial bits per scan frame

    // ROM word, written per byte and read whole
    // bytes[0] is the even download address, bytes[1] the odd one
    typedef union packed {
        logic [DATAW-1:0]         word;
        logic [DATAW/8-1:0][7:0]  bytes;
    } rom_word_u;

endpackage

// File: neptuno_rom_loader.sv
// ROM download packer
// Collects the byte stream from the I/O controller into 16-bit ROM
// words. An even byte waits for its odd partner; a lone even byte is
// flushed as a masked write when the next byte misses or the download ends.

`timescale 1ns/1ps

module neptuno_rom_loader #(
    parameter int ADDRW = 8
) (
    input  logic                     sample,
    input  logic                     rst,
    input  logic                     downloading,
    input  logic [ADDRW+1:0]         ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    output logic                     prog_we,
    output logic                     prog_ba,
    output logic [ADDRW-1:0]         prog_addr,
    output neptuno_pkg::rom_word_u   prog_data,
    output logic [1:0]               prog_mask
);

    logic             pend;        // Even byte waiting for its partner
    logic             pend_ba;
    logic [ADDRW-1:0] pend_addr;
    logic [7:0]       pend_byte;

    logic             wr_ba;
    logic [ADDRW-1:0] wr_addr;
    logic             wr_odd;
    logic             match;

    assign wr_ba   = ioctl_addr[ADDRW+1];
    assign wr_addr = ioctl_addr[ADDRW:1];
    assign wr_odd  = ioctl_addr[0];
    assign match   = pend && pend_ba == wr_ba && pend_addr == wr_addr;

    always_ff @(posedge sample) begin
        if (rst) begin
            prog_we <= 1'b0;
            pend    <= 1'b0;
        end else begin
            prog_we <= 1'b0;
            if (ioctl_wr) begin
                if (wr_odd) begin
                    prog_we <= 1'b1;
                    if (match)
                        pend <= 1'b0;
                end else begin
                    prog_we <= pend;   // Flush the older even byte
                    pend    <= 1'b1;
                end
            end else if (pend && !downloading) begin
                prog_we <= 1'b1;       // Download ended on an even byte
                pend    <= 1'b0;
            end
        end
    end

    always_ff @(posedge sample) begin
        if (ioctl_wr && wr_odd) begin
            prog_ba             <= wr_ba;
            prog_addr           <= wr_addr;
            prog_data.bytes[0]  <= pend_byte;
            prog_data.bytes[1]  <= ioctl_data;
            prog_mask           <= match ? 2'b00 : 2'b01;  // Lone odd byte writes high only
        end else if (ioctl_wr || !downloading) begin
            prog_ba             <= pend_ba;
            prog_addr           <= pend_addr;
            prog_data.bytes[0]  <= pend_byte;
            prog_data.bytes[1]  <= 8'h00;
            prog_mask           <= 2'b10;                  // Low byte only
        end
        if (ioctl_wr && !wr_odd) begin
            pend_ba   <= wr_ba;
            pend_addr <= wr_addr;
            pend_byte <= ioctl_data;
        end
    end

endmodule

// File: neptuno_rom_ctrl.sv
// ROM memory controller
// Two read banks share one on-chip word memory. Requests are acked one
// per cycle, oldest-served bank first, and the word follows two cycles
// after the ack with a data-ok pulse. Downloads write bytes under a mask.

`timescale 1ns/1ps

module neptuno_rom_ctrl #(
    parameter int ADDRW = 8
) (
    input  logic                                sample,
    input  logic                                rst,
    input  logic                                downloading,
    input  logic                                prog_we,
    input  logic                                prog_ba,
    input  logic [ADDRW-1:0]                    prog_addr,
    input  neptuno_pkg::rom_word_u              prog_data,
    input  logic [1:0]                          prog_mask,
    input  logic [neptuno_pkg::NBANKS-1:0]      ba_rd,
    input  logic [ADDRW-1:0]                    ba0_addr,
    input  logic [ADDRW-1:0]                    ba1_addr,
    output logic [neptuno_pkg::NBANKS-1:0]      ba_ack,
    output logic [neptuno_pkg::NBANKS-1:0]      ba_dok,
    output logic [neptuno_pkg::DATAW-1:0]       ba0_dout,
    output logic [neptuno_pkg::DATAW-1:0]       ba1_dout
);

    localparam int DEPTH = neptuno_pkg::NBANKS * (2 ** ADDRW);

    neptuno_pkg::rom_word_u mem [0:DEPTH-1];

    logic [neptuno_pkg::NBANKS-1:0] req;
    logic                           grant_v;
    logic                           grant_b;
    logic [ADDRW-1:0]               grant_addr;
    logic                           last;      // Bank served most recently

    // Pipeline, {bank, word} index per stage
    logic [ADDRW:0]                 idx1;
    logic [ADDRW:0]                 idx2;
    logic                           v2;
    neptuno_pkg::rom_word_u         rd_word;

    // A bank acked last cycle is still showing its old request
    assign req = ba_rd & ~ba_ack & {neptuno_pkg::NBANKS{~downloading}};

    always_comb begin
        grant_v = |req;
        if (req[0] && req[1])
            grant_b = ~last;   // Both waiting, take turns
        else
            grant_b = req[1];
        grant_addr = grant_b ? ba1_addr : ba0_addr;
    end

    always_ff @(posedge sample) begin
        if (rst) begin
            ba_ack <= '0;
            ba_dok <= '0;
            v2     <= 1'b0;
            last   <= 1'b1;    // Bank 0 goes first
        end else begin
            ba_ack <= '0;
            if (grant_v) begin
                ba_ack[grant_b] <= 1'b1;
                last            <= grant_b;
            end
            v2     <= |ba_ack;
            ba_dok <= '0;
            if (v2)
                ba_dok[idx2[ADDRW]] <= 1'b1;
        end
    end

    always_ff @(posedge sample) begin
        if (grant_v)
            idx1 <= {grant_b, grant_addr};
        idx2 <= idx1;
    end

    // Memory is read one cycle after the ack so that a write in the
    // ack cycle lands first
    always_ff @(posedge sample) begin
        if (prog_we) begin
            for (int b = 0; b < 2; b++) begin
                if (!prog_mask[b])
                    mem[{prog_ba, prog_addr}].bytes[b] <= prog_data.bytes[b];
            end
        end
        rd_word <= mem[idx2];
    end

    assign ba0_dout = rd_word.word;   // Valid with ba_dok[0]
    assign ba1_dout = rd_word.word;   // Valid with ba_dok[1]

endmodule

// File: neptuno_joy_scan.sv
// DB9 joystick scanner
// Drives the load and clock pins of the external shift register and
// reads both joysticks back serially, MSB of joystick 1 first.
// Pins are active low; the decoded joysticks are active high.

`timescale 1ns/1ps

module neptuno_joy_scan #(
    parameter int JOY_DIV = 4
) (
    input  logic                          sample,
    input  logic                          rst,
    input  logic                          joy_data,
    output logic                          joy_load,
    output logic                          joy_clk,
    output logic [neptuno_pkg::JOYW-1:0]  joy1,
    output logic [neptuno_pkg::JOYW-1:0]  joy2
);

    localparam int LAST_STEP = 2 * neptuno_pkg::JOY_BITS;  // Half periods per frame, minus one
    localparam int STEPW     = $clog2(LAST_STEP + 1);
    localparam int CNTW      = $clog2(JOY_DIV + 1);

    logic [CNTW-1:0]                   cnt;
    logic                              tick;
    logic [STEPW-1:0]                  step;
    logic [STEPW-1:0]                  next_step;
    logic                              done;
    logic [neptuno_pkg::JOY_BITS-1:0]  shreg;

    assign tick      = cnt == CNTW'(JOY_DIV - 1);
    assign next_step = (step == STEPW'(LAST_STEP)) ? '0 : step + 1'b1;

    // Step 0 is the load pulse, odd steps clock low, even steps clock high
    always_ff @(posedge sample) begin
        if (rst) begin
            cnt      <= '0;
            step     <= STEPW'(LAST_STEP);
            joy_load <= 1'b1;
            joy_clk  <= 1'b1;
            done     <= 1'b0;
            joy1     <= '0;
            joy2     <= '0;
        end else begin
            cnt  <= tick ? '0 : cnt + 1'b1;
            done <= tick && next_step == STEPW'(LAST_STEP);
            if (tick) begin
                step     <= next_step;
                joy_load <= next_step != '0;
                joy_clk  <= !next_step[0];
            end
            if (done) begin
                joy1 <= ~shreg[neptuno_pkg::JOY_BITS-1 -: neptuno_pkg::JOYW];
                joy2 <= ~shreg[neptuno_pkg::JOYW-1:0];
            end
        end
    end

    // Sample on the rising clock edge, before the register moves on
    always_ff @(posedge sample) begin
        if (tick && !next_step[0] && next_step != '0)
            shreg <= {shreg[neptuno_pkg::JOY_BITS-2:0], joy_data};
    end

endmodule

// File: neptuno_sigma_delta.sv
// First-order sigma-delta DAC
// The signed sample becomes offset binary and is added to an accumulator
// each cycle; the registered carry is the one-bit audio output.

`timescale 1ns/1ps

module neptuno_sigma_delta #(
    parameter int SNDW = 16
) (
    input  logic                   sample,
    input  logic                   rst,
    input  logic signed [SNDW-1:0] snd,
    output logic                   dout
);

    logic [SNDW-1:0] level;
    logic [SNDW-1:0] acc;
    logic [SNDW:0]   sum;

    assign level = {~snd[SNDW-1], snd[SNDW-2:0]};   // Offset binary
    assign sum   = {1'b0, acc} + {1'b0, level};

    always_ff @(posedge sample) begin
        if (rst) begin
            acc  <= '0;
            dout <= 1'b0;
        end else begin
            acc  <= sum[SNDW-1:0];
            dout <= sum[SNDW];       // Pulse density follows the level
        end
    end

endmodule

// File: neptuno_top.sv
// NeptUNO board shell
// ROM download, banked ROM reads, DB9 joystick scanning and sigma-delta
// audio around an external game core, all on the sample clock

`timescale 1ns/1ps

module neptuno_top #(
    parameter int ADDRW   = 8,
    parameter int JOY_DIV = 4,
    parameter int SNDW    = 16
) (
    input  logic                                sample,
    input  logic                                rst,
    // ROM download
    input  logic                                downloading,
    input  logic [ADDRW+1:0]                    ioctl_addr,
    input  logic [7:0]                          ioctl_data,
    input  logic                                ioctl_wr,
    // Game ROM reads
    input  logic [neptuno_pkg::NBANKS-1:0]      ba_rd,
    input  logic [ADDRW-1:0]                    ba0_addr,
    input  logic [ADDRW-1:0]                    ba1_addr,
    output logic [neptuno_pkg::NBANKS-1:0]      ba_ack,
    output logic [neptuno_pkg::NBANKS-1:0]      ba_dok,
    output logic [neptuno_pkg::DATAW-1:0]       ba0_dout,
    output logic [neptuno_pkg::DATAW-1:0]       ba1_dout,
    // DB9 joysticks
    input  logic                                joy_data,
    output logic                                joy_load,
    output logic                                joy_clk,
    output logic [neptuno_pkg::JOYW-1:0]        joy1,
    output logic [neptuno_pkg::JOYW-1:0]        joy2,
    // Sound
    input  logic signed [SNDW-1:0]              snd_left,
    input  logic signed [SNDW-1:0]              snd_right,
    output logic                                audio_l,
    output logic                                audio_r
);

    logic                    prog_we;
    logic                    prog_ba;
    logic [ADDRW-1:0]        prog_addr;
    neptuno_pkg::rom_word_u  prog_data;
    logic [1:0]              prog_mask;

    neptuno_rom_loader #(.ADDRW(ADDRW)) u_loader (
        .sample      ( sample      ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_we     ( prog_we     ),
        .prog_ba     ( prog_ba     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   )
    );

    neptuno_rom_ctrl #(.ADDRW(ADDRW)) u_rom (
        .sample      ( sample      ),
        .rst         ( rst         ),
        .downloading ( downloading ),   // Holds off new acks
        .prog_we     ( prog_we     ),
        .prog_ba     ( prog_ba     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .ba_rd       ( ba_rd       ),
        .ba0_addr    ( ba0_addr    ),
        .ba1_addr    ( ba1_addr    ),
        .ba_ack      ( ba_ack      ),
        .ba_dok      ( ba_dok      ),
        .ba0_dout    ( ba0_dout    ),
        .ba1_dout    ( ba1_dout    )
    );

    neptuno_joy_scan #(.JOY_DIV(JOY_DIV)) u_joy (
        .sample      ( sample      ),
        .rst         ( rst         ),
        .joy_data    ( joy_data    ),
        .joy_load    ( joy_load    ),
        .joy_clk     ( joy_clk     ),
        .joy1        ( joy1        ),
        .joy2        ( joy2        )
    );

    // One DAC per channel
    neptuno_sigma_delta #(.SNDW(SNDW)) u_dac_l (
        .sample      ( sample      ),
        .rst         ( rst         ),
        .snd         ( snd_left    ),
        .dout        ( audio_l     )
    );

    neptuno_sigma_delta #(.SNDW(SNDW)) u_dac_r (
        .sample      ( sample      ),
        .rst         ( rst         ),
        .snd         ( snd_right   ),
        .dout        ( audio_r     )
    );

endmodule

// File: neptuno_tb.sv
// NeptUNO board shell testbench
// Random download, banked read-back, arbitration, back-pressure,
// joystick scan and sigma-delta density checks against a reference model

`timescale 1ns/1ps

module neptuno_tb;

    localparam int ADDRW   = 8;
    localparam int JOY_DIV = 4;
    localparam int SNDW    = 16;
    localparam int NWORDS  = neptuno_pkg::NBANKS * (2 ** ADDRW);
    localparam int FRAME   = (1 + 2 * neptuno_pkg::JOY_BITS) * JOY_DIV;
    // Worst case per test in cycles plus margin
    localparam int WD_CYCLES = NWORDS * 2 * 2 + NWORDS * 8 + 200 + 400 + 100
                             + 4 * (2 * FRAME + 2) + 2 * 4100 + 2000;

    logic                               sample;
    logic                               rst;
    logic                               downloading;
    logic [ADDRW+1:0]                   ioctl_addr;
    logic [7:0]                         ioctl_data;
    logic                               ioctl_wr;
    logic [neptuno_pkg::NBANKS-1:0]     ba_rd;
    logic [ADDRW-1:0]                   ba0_addr;
    logic [ADDRW-1:0]                   ba1_addr;
    logic [neptuno_pkg::NBANKS-1:0]     ba_ack;
    logic [neptuno_pkg::NBANKS-1:0]     ba_dok;
    logic [neptuno_pkg::DATAW-1:0]      ba0_dout;
    logic [neptuno_pkg::DATAW-1:0]      ba1_dout;
    logic                               joy_data;
    logic                               joy_load;
    logic                               joy_clk;
    logic [neptuno_pkg::JOYW-1:0]       joy1;
    logic [neptuno_pkg::JOYW-1:0]       joy2;
    logic signed [SNDW-1:0]             snd_left;
    logic signed [SNDW-1:0]             snd_right;
    logic                               audio_l;
    logic                               audio_r;

    logic [31:0] lfsr = 32'h479f18ad;
    int          errors = 0;
    int          tests = 0;

    // Reference ROM and download model state
    logic [15:0]      ref_rom [0:NWORDS-1];
    logic             m_pend = 1'b0;
    logic [ADDRW:0]   m_word;
    logic [7:0]       m_byte;

    // Expected data-ok events in arrival order
    int               exp_due[$];
    int               exp_bank[$];
    logic [15:0]      exp_data[$];
    int               cyc = 0;
    logic             prev_dl = 1'b0;
    logic             alt_on = 1'b0;
    logic             ack_seen = 1'b0;
    int               last_b = 0;
    logic             overlap = 1'b0;
    int               ack_count = 0;
    int               dok_count = 0;

    // Joystick shift-register model
    logic [7:0]       j1 = 8'h00;
    logic [7:0]       j2 = 8'h00;
    logic [15:0]      joy_sr = 16'hffff;

    neptuno_top #(.ADDRW(ADDRW), .JOY_DIV(JOY_DIV), .SNDW(SNDW)) UUT (
        .sample(sample), .rst(rst), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .ba_rd(ba_rd), .ba0_addr(ba0_addr), .ba1_addr(ba1_addr),
        .ba_ack(ba_ack), .ba_dok(ba_dok), .ba0_dout(ba0_dout), .ba1_dout(ba1_dout),
        .joy_data(joy_data), .joy_load(joy_load), .joy_clk(joy_clk),
        .joy1(joy1), .joy2(joy2),
        .snd_left(snd_left), .snd_right(snd_right), .audio_l(audio_l), .audio_r(audio_r)
    );

    initial begin
        sample = 1'b0;
        forever #20 sample = ~sample;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // External PISO register that loads while joy_load is low
    always @(negedge joy_load or posedge joy_clk) begin
        if (!joy_load)
            joy_sr <= {~j1, ~j2};
        else
            joy_sr <= {joy_sr[14:0], 1'b1};
    end
    assign joy_data = joy_sr[15];

    // Read monitor for ack and dok timing, arbitration and data
    always @(negedge sample) begin
        logic [15:0] dout;
        logic [7:0]  a;
        if (!rst) begin
            cyc++;
            for (int b = 0; b < 2; b++) begin
                if (ba_dok[b]) begin
                    dok_count++;
                    dout = b ? ba1_dout : ba0_dout;
                    assert (exp_due.size() > 0 && exp_due[0] == cyc && exp_bank[0] == b) else begin
                        $display("FAIL %0t: unexpected dok on bank %0d", $time, b);
                        errors++;
                    end
                    if (exp_due.size() > 0 && exp_due[0] == cyc) begin
                        assert (dout == exp_data[0]) else begin
                            $display("FAIL %0t: bank %0d data %h, expected %h",
                                     $time, b, dout, exp_data[0]);
                            errors++;
                        end
                        void'(exp_due.pop_front());
                        void'(exp_bank.pop_front());
                        void'(exp_data.pop_front());
                    end
                end
            end
            if (exp_due.size() > 0) begin
                assert (exp_due[0] > cyc) else begin
                    $display("FAIL %0t: missing dok on bank %0d", $time, exp_bank[0]);
                    errors++;
                end
                if (exp_due[0] <= cyc) begin
                    void'(exp_due.pop_front());
                    void'(exp_bank.pop_front());
                    void'(exp_data.pop_front());
                end
            end
            assert (ba_ack != 2'b11) else begin
                $display("FAIL %0t: both banks acked in one cycle", $time);
                errors++;
            end
            assert (ba_ack == 2'b00 || !prev_dl) else begin
                $display("FAIL %0t: ack given while downloading", $time);
                errors++;
            end
            for (int b = 0; b < 2; b++) begin
                if (ba_ack[b]) begin
                    a = b ? ba1_addr : ba0_addr;
                    exp_due.push_back(cyc + 2);
                    exp_bank.push_back(b);
                    exp_data.push_back(ref_rom[{b[0], a}]);
                    assert (!(alt_on && ack_seen) || b != last_b) else begin
                        $display("FAIL %0t: bank %0d acked twice in a row", $time, b);
                        errors++;
                    end
                    last_b   = b;
                    ack_seen = 1'b1;
                    ack_count++;
                end
            end
            if (exp_due.size() >= 2)
                overlap = 1'b1;
            prev_dl = downloading;
        end
    end

    task automatic send_byte(input logic [ADDRW+1:0] a, input logic [7:0] d);
        if (!a[0]) begin
            if (m_pend)
                ref_rom[m_word][7:0] = m_byte;   // Older even byte goes alone
            m_pend = 1'b1;
            m_word = a[ADDRW+1:1];
            m_byte = d;
        end else if (m_pend && m_word == a[ADDRW+1:1]) begin
            ref_rom[m_word] = {d, m_byte};
            m_pend = 1'b0;
        end else begin
            ref_rom[a[ADDRW+1:1]][15:8] = d;
        end
        @(posedge sample);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge sample);
        ioctl_wr   <= 1'b0;
    endtask

    task automatic end_download();
        @(posedge sample);
        downloading <= 1'b0;
        if (m_pend)
            ref_rom[m_word][7:0] = m_byte;
        m_pend = 1'b0;
        repeat (3) @(posedge sample);
    endtask

    task automatic read_word(input int b, input logic [ADDRW-1:0] a);
        int n;
        n = 0;
        @(posedge sample);
        ba_rd[b] <= 1'b1;
        if (b == 0)
            ba0_addr <= a;
        else
            ba1_addr <= a;
        do begin
            @(negedge sample);
            n++;
        end while (!ba_ack[b] && n < 20);
        assert (ba_ack[b]) else begin
            $display("FAIL %0t: no ack for bank %0d address %h", $time, b, a);
            errors++;
        end
        @(posedge sample);
        ba_rd[b] <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_due.size() > 0 && n < 20) begin
            @(negedge sample);
            n++;
        end
        assert (exp_due.size() == 0) else begin
            $display("Reads did not complete: %0d still outstanding", exp_due.size());
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - start_err);
    endtask

    task automatic check_density(input logic signed [SNDW-1:0] l,
                                 input logic signed [SNDW-1:0] r);
        int ones_l;
        int ones_r;
        int exp_l;
        int exp_r;
        ones_l = 0;
        ones_r = 0;
        exp_l  = int'(l ^ 16'h8000) * 4096 / 65536;
        exp_r  = int'(r ^ 16'h8000) * 4096 / 65536;
        @(posedge sample);
        snd_left  <= l;
        snd_right <= r;
        repeat (3) @(negedge sample);   // Let the old level flush out
        repeat (4096) begin
            @(negedge sample);
            ones_l += audio_l;
            ones_r += audio_r;
        end
        assert (ones_l >= exp_l - 1 && ones_l <= exp_l + 1) else begin
            $display("FAIL %0t: left ones %0d, expected %0d", $time, ones_l, exp_l);
            errors++;
        end
        assert (ones_r >= exp_r - 1 && ones_r <= exp_r + 1) else begin
            $display("FAIL %0t: right ones %0d, expected %0d", $time, ones_r, exp_r);
            errors++;
        end
    endtask

    initial begin
        int          e;
        int          n;
        int          acks0;
        int          doks0;
        int          low_cyc;
        int          clk_rise;
        int          reload;
        logic        clk_prev;
        logic [ADDRW:0] w;
        rst = 1'b1;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        ba_rd = '0;
        ba0_addr = '0;
        ba1_addr = '0;
        snd_left = '0;
        snd_right = '0;
        repeat (2) @(posedge sample);
        rst <= 1'b0;

        // Full-word download over both banks and read back
        e = errors;
        @(posedge sample);
        downloading <= 1'b1;
        for (int i = 0; i < 2 * NWORDS; i++)
            send_byte(i[ADDRW+1:0], rand_bits(8));
        end_download();
        for (int i = 0; i < NWORDS; i++)
            read_word(i / (2 ** ADDRW), i[ADDRW-1:0]);
        wait_drain();
        finish_test("full-word download", e);

        // Lone even bytes flushed by a mismatch and by the end of download
        e = errors;
        @(posedge sample);
        downloading <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            w = rand_bits(ADDRW + 1);
            send_byte({w, 1'b0}, rand_bits(8));
            send_byte({w + 1'b1, 1'b0}, rand_bits(8));
            send_byte({w + 1'b1, 1'b1}, rand_bits(8));
        end
        w = rand_bits(ADDRW + 1);
        send_byte({w, 1'b0}, rand_bits(8));
        end_download();
        for (int i = 0; i < NWORDS; i++)
            read_word(i / (2 ** ADDRW), i[ADDRW-1:0]);
        wait_drain();
        finish_test("masked flush", e);

        // Both banks held with random addresses renewed on every ack
        e = errors;
        alt_on   = 1'b1;
        ack_seen = 1'b0;
        overlap  = 1'b0;
        acks0    = ack_count;
        @(posedge sample);
        ba_rd    <= 2'b11;
        ba0_addr <= rand_bits(ADDRW);
        ba1_addr <= rand_bits(ADDRW);
        repeat (200) begin
            @(negedge sample);
            n = ba_ack;
            @(posedge sample);
            if (n[0])
                ba0_addr <= rand_bits(ADDRW);
            if (n[1])
                ba1_addr <= rand_bits(ADDRW);
        end
        ba_rd <= 2'b00;
        wait_drain();
        alt_on = 1'b0;
        assert (overlap && ack_count - acks0 >= 190) else begin
            $display("FAIL %0t: %0d acks, overlap %0b", $time, ack_count - acks0, overlap);
            errors++;
        end
        finish_test("arbitration", e);

        // Acks stop while downloading but acked reads still finish
        e = errors;
        @(posedge sample);
        ba_rd    <= 2'b11;
        ba0_addr <= rand_bits(ADDRW);
        ba1_addr <= rand_bits(ADDRW);
        n = 0;
        do begin
            @(negedge sample);
            n++;
        end while (ba_ack == 2'b00 && n < 20);
        @(posedge sample);
        downloading <= 1'b1;
        doks0 = dok_count;
        repeat (20) @(posedge sample);
        assert (dok_count > doks0) else begin
            $display("FAIL %0t: no dok after downloading rose", $time);
            errors++;
        end
        downloading <= 1'b0;
        repeat (10) @(posedge sample);
        ba_rd <= 2'b00;
        wait_drain();
        finish_test("back-pressure", e);

        // Joystick frames with load and clock pin timing
        e = errors;
        for (int i = 0; i < 4; i++) begin
            j1 = rand_bits(8);
            j2 = rand_bits(8);
            @(negedge joy_load);
            low_cyc  = 0;
            clk_rise = 0;
            reload   = 0;
            clk_prev = 1'b1;
            for (int k = 1; k <= FRAME + 1; k++) begin
                @(negedge sample);
                if (!joy_load && k <= FRAME)
                    low_cyc++;
                if (!joy_load && k > JOY_DIV && reload == 0)
                    reload = k;   // Start of the next frame
                if (joy_clk && !clk_prev)
                    clk_rise++;
                clk_prev = joy_clk;
            end
            assert (low_cyc == JOY_DIV && reload == FRAME + 1
                    && clk_rise == neptuno_pkg::JOY_BITS) else begin
                $display("FAIL %0t: load low %0d cycles, next load at %0d, %0d clock rises",
                         $time, low_cyc, reload, clk_rise);
                errors++;
            end
            assert (joy1 == j1 && joy2 == j2) else begin
                $display("FAIL %0t: joysticks %h %h, expected %h %h",
                         $time, joy1, joy2, j1, j2);
                errors++;
            end
        end
        finish_test("joystick scan", e);

        // Sigma-delta pulse density
        e = errors;
        check_density(rand_bits(SNDW), rand_bits(SNDW));
        check_density(rand_bits(SNDW), rand_bits(SNDW));
        finish_test("audio density", e);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #(WD_CYCLES * 40.0);
        $display("Timeout: the tests did not finish within %0d cycles", WD_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: neptuno.f
neptuno_pkg.sv
neptuno_rom_loader.sv
neptuno_rom_ctrl.sv
neptuno_joy_scan.sv
neptuno_sigma_delta.sv
neptuno_top.sv
neptuno_tb.sv

// File: Bender.yml
package:
  name: neptuno

sources:
  - neptuno_pkg.sv
  - neptuno_rom_loader.sv
  - neptuno_rom_ctrl.sv
  - neptuno_joy_scan.sv
  - neptuno_sigma_delta.sv
  - neptuno_top.sv
  - target: test
    files:
      - neptuno_tb.sv
